// ==== eeprom_consts.svh ====
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// 2K x 8 serial eeprom
`define EE_ADDR_W 11
`define EE_DATA_W 8

`define EE_DEV_CODE 4'b1010 // upper nibble of every control byte

// CLK cycles per quarter of an SCL bit, any value >= 1
`define EE_QTR_CYCLES 2

`endif

// ==== i2c_bus_pkg.sv ====
package i2c_bus_pkg;

    typedef logic [7:0] byte_t;

    // commands accepted by the bit engine
    typedef enum logic [2:0] {
        CMD_START,
        CMD_RSTART,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bus_cmd_t;

    // quarters of one SCL bit
    typedef enum logic [1:0] {
        PH_LOW,  // scl low, sda setup
        PH_RISE, // scl high
        PH_HIGH, // scl high, sample point
        PH_FALL  // scl low
    } bit_phase_t;

endpackage

// ==== eeprom_xfer_pkg.sv ====
`include "eeprom_consts.svh"

package eeprom_xfer_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [`EE_DATA_W-1:0] ee_data_t;

    // device code, block bits, r/w bit
    typedef logic [7:0] ctrl_byte_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_W,
        RSTART,
        CTRL_R,
        DATA_R,
        STOP,
        DONE
    } xfer_state_t;

endpackage

// ==== i2c_bit_engine.sv ====
`include "eeprom_consts.svh"

module i2c_bit_engine
    import i2c_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     cmd_req,
    input  bus_cmd_t cmd,
    input  byte_t    tx_byte,
    input  logic     send_nack,
    input  logic     sda_in,
    output logic     cmd_ack,
    output byte_t    rx_byte,
    output logic     slave_nack,
    output logic     scl,
    output logic     sda_pull_low
);

    localparam int QW = $clog2(`EE_QTR_CYCLES + 1);
    localparam logic [QW-1:0] QTR_LAST = QW'(`EE_QTR_CYCLES - 1);

    logic          busy;
    bus_cmd_t      cur_cmd;
    bit_phase_t    phase;
    logic [QW-1:0] qcnt;
    logic [3:0]    bit_cnt;  // 0..7 data, 8 ack
    byte_t         tx_sh;
    logic          nack_bit; // master nack on a read
    logic          byte_cmd;
    logic          qtr_end;
    logic          last_bit;
    logic          sample;
    logic          scl_d;
    logic          sda_d;

    assign byte_cmd = (cur_cmd == CMD_WRITE) || (cur_cmd == CMD_READ);
    assign qtr_end  = (qcnt == QTR_LAST);
    assign last_bit = byte_cmd ? (bit_cnt == 4'd8) : 1'b1;
    assign sample   = (phase == PH_HIGH) && (qcnt == '0);

    // bus levels for the current quarter
    always_comb
    begin
        scl_d = 1'b0;
        sda_d = 1'b0;
        case (cur_cmd)
            CMD_START, CMD_RSTART:
            begin
                scl_d = (phase == PH_RISE) || (phase == PH_HIGH);
                sda_d = (phase == PH_HIGH) || (phase == PH_FALL); // falls while scl high
            end
            CMD_STOP:
            begin
                scl_d = (phase != PH_LOW);
                sda_d = (phase == PH_LOW) || (phase == PH_RISE); // rises while scl high
            end
            CMD_WRITE:
            begin
                scl_d = (phase == PH_RISE) || (phase == PH_HIGH);
                sda_d = (bit_cnt != 4'd8) && !tx_sh[7]; // released for slave ack
            end
            default:
            begin
                scl_d = (phase == PH_RISE) || (phase == PH_HIGH);
                sda_d = (bit_cnt == 4'd8) && !nack_bit;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy         <= 1'b0;
            cmd_ack      <= 1'b0;
            phase        <= PH_LOW;
            qcnt         <= '0;
            bit_cnt      <= '0;
            slave_nack   <= 1'b0;
            scl          <= 1'b1; // bus idle
            sda_pull_low <= 1'b0;
        end
        else if (busy)
        begin
            scl          <= scl_d;
            sda_pull_low <= sda_d;

            if (qtr_end)
            begin
                qcnt  <= '0;
                phase <= bit_phase_t'(phase + 2'd1);
                if (phase == PH_FALL)
                begin
                    tx_sh <= {tx_sh[6:0], 1'b0}; // msb first
                    if (last_bit)
                    begin
                        busy    <= 1'b0;
                        cmd_ack <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
            end
            else
            begin
                qcnt <= qcnt + 1'b1;
            end

            if (sample)
            begin
                if (cur_cmd == CMD_READ && bit_cnt != 4'd8)
                    rx_byte <= {rx_byte[6:0], sda_in};
                if (cur_cmd == CMD_WRITE && bit_cnt == 4'd8)
                    slave_nack <= sda_in; // high means no ack
            end
        end
        else if (cmd_ack)
        begin
            if (!cmd_req)
                cmd_ack <= 1'b0;
        end
        else if (cmd_req)
        begin
            // bus levels hold between commands until the next quarter
            busy       <= 1'b1;
            cur_cmd    <= cmd;
            tx_sh      <= tx_byte;
            nack_bit   <= send_nack;
            bit_cnt    <= '0;
            phase      <= PH_LOW;
            qcnt       <= '0;
            slave_nack <= 1'b0;
        end
    end

endmodule

// ==== eeprom_xfer_fsm.sv ====
`include "eeprom_consts.svh"

module eeprom_xfer_fsm
    import i2c_bus_pkg::*;
    import eeprom_xfer_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     req,
    input  logic     we,
    input  ee_addr_t addr,
    input  ee_data_t wdata,
    input  logic     cmd_ack,
    input  byte_t    rx_byte,
    input  logic     slave_nack,
    output logic     ack,
    output ee_data_t rdata,
    output logic     nack,
    output logic     cmd_req,
    output bus_cmd_t cmd,
    output byte_t    tx_byte,
    output logic     send_nack
);

    xfer_state_t state;
    ctrl_byte_t  ctrl_w;
    ctrl_byte_t  ctrl_r;
    logic        done;

    // block select goes in the control byte
    assign ctrl_w = {`EE_DEV_CODE, addr[`EE_ADDR_W-1:8], 1'b0};
    assign ctrl_r = {`EE_DEV_CODE, addr[`EE_ADDR_W-1:8], 1'b1};
    assign done   = cmd_req && cmd_ack;

    always_comb
    begin
        cmd       = CMD_STOP;
        tx_byte   = '0;
        send_nack = 1'b0;
        case (state)
            START:  cmd = CMD_START;
            RSTART: cmd = CMD_RSTART;
            CTRL_W:
            begin
                cmd     = CMD_WRITE;
                tx_byte = ctrl_w;
            end
            ADDR:
            begin
                cmd     = CMD_WRITE;
                tx_byte = addr[7:0];
            end
            DATA_W:
            begin
                cmd     = CMD_WRITE;
                tx_byte = wdata;
            end
            CTRL_R:
            begin
                cmd     = CMD_WRITE;
                tx_byte = ctrl_r;
            end
            DATA_R:
            begin
                cmd       = CMD_READ;
                send_nack = 1'b1; // single byte, master nacks it
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= IDLE;
            cmd_req <= 1'b0;
            ack     <= 1'b0;
            nack    <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (req)
                    begin
                        nack  <= 1'b0;
                        state <= START;
                    end
                DONE:
                    if (!req) // hold ack until host answers
                    begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                default:
                    if (done)
                    begin
                        cmd_req <= 1'b0;
                        case (state)
                            START:  state <= CTRL_W;
                            RSTART: state <= CTRL_R;
                            CTRL_W, ADDR, CTRL_R:
                                if (slave_nack)
                                begin
                                    nack  <= 1'b1;
                                    state <= STOP;
                                end
                                else if (state == CTRL_W)
                                    state <= ADDR;
                                else if (state == CTRL_R)
                                    state <= DATA_R;
                                else
                                    state <= we ? DATA_W : RSTART;
                            DATA_W:
                            begin
                                nack  <= slave_nack;
                                state <= STOP;
                            end
                            DATA_R:
                            begin
                                rdata <= rx_byte;
                                state <= STOP;
                            end
                            default:
                            begin
                                ack   <= 1'b1; // stop sent
                                state <= DONE;
                            end
                        endcase
                    end
                    else if (!cmd_req && !cmd_ack)
                    begin
                        cmd_req <= 1'b1;
                    end
            endcase
        end
    end

endmodule

// ==== eeprom_ctrl_top.sv ====
`include "eeprom_consts.svh"

module eeprom_ctrl_top
    import i2c_bus_pkg::*;
    import eeprom_xfer_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     req,
    input  logic     we,
    input  ee_addr_t addr,
    input  ee_data_t wdata,
    input  logic     sda_in,
    output logic     ack,
    output ee_data_t rdata,
    output logic     nack,
    output logic     scl,
    output logic     sda_pull_low
);

    logic     cmd_req;
    logic     cmd_ack;
    bus_cmd_t cmd;
    byte_t    tx_byte;
    byte_t    rx_byte;
    logic     send_nack;
    logic     slave_nack;

    eeprom_xfer_fsm u_xfer (
        .CLK        (CLK),
        .RESET      (RESET),
        .req        (req),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .cmd_ack    (cmd_ack),
        .rx_byte    (rx_byte),
        .slave_nack (slave_nack),
        .ack        (ack),
        .rdata      (rdata),
        .nack       (nack),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .tx_byte    (tx_byte),
        .send_nack  (send_nack)
    );

    i2c_bit_engine u_bit (
        .CLK          (CLK),
        .RESET        (RESET),
        .cmd_req      (cmd_req),
        .cmd          (cmd),
        .tx_byte      (tx_byte),
        .send_nack    (send_nack),
        .sda_in       (sda_in),
        .cmd_ack      (cmd_ack),
        .rx_byte      (rx_byte),
        .slave_nack   (slave_nack),
        .scl          (scl),
        .sda_pull_low (sda_pull_low)
    );

endmodule

// ==== tb_eeprom_model.sv ====
`include "eeprom_consts.svh"

module tb_eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic enable,
    output logic sda_pull_low
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]            mem [0:(1 << `EE_ADDR_W) - 1];
    logic [`EE_ADDR_W-1:0] ptr;
    logic [7:0]            sh;
    logic [3:0]            bit_cnt;  // 8 after the last data bit, 9 after the ack clock
    int                    byte_idx;
    logic                  rd;
    logic                  active;   // addressed since the last start
    logic                  sending;  // read data phase
    logic                  scl_q = 1'b1;
    logic                  sda_q = 1'b1;

    initial
    begin
        logic [10:0] a;

        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
        begin
            a = i[10:0];
            mem[i] = a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
        end
        ptr          = '0;
        sh           = '0;
        bit_cnt      = '0;
        byte_idx     = 0;
        rd           = 1'b0;
        active       = 1'b0;
        sending      = 1'b0;
        sda_pull_low = 1'b0;
    end

    // control, address or write data byte complete
    task take_byte;
        if (!enable || (byte_idx == 0 && sh[7:4] != `EE_DEV_CODE))
        begin
            active = 1'b0; // no ack, stays off the bus
        end
        else
        begin
            case (byte_idx)
                0:
                begin
                    ptr[10:8] = sh[3:1];
                    rd        = sh[0];
                end
                1:       ptr[7:0] = sh;
                default: mem[ptr] = sh;
            endcase
            sda_pull_low = 1'b1;
        end
    endtask

    task clock_rise;
        if (active && !sending)
        begin
            if (bit_cnt < 4'd8)
                sh = {sh[6:0], sda};
            bit_cnt = bit_cnt + 4'd1;
        end
        else if (active)
        begin
            if (bit_cnt == 4'd8 && sda)
            begin
                // master nack ends the read
                active  = 1'b0;
                sending = 1'b0;
            end
            bit_cnt = bit_cnt + 4'd1;
        end
    endtask

    task clock_fall;
        if (active && !sending)
        begin
            if (bit_cnt == 4'd8)
            begin
                take_byte();
            end
            else if (bit_cnt == 4'd9)
            begin
                sda_pull_low = 1'b0;
                bit_cnt      = '0;
                byte_idx     = byte_idx + 1;
                if (byte_idx == 1 && rd)
                begin
                    sending      = 1'b1;
                    sh           = mem[ptr];
                    sda_pull_low = !sh[7];
                end
            end
        end
        else if (active)
        begin
            if (bit_cnt < 4'd8)
                sda_pull_low = !sh[7 - bit_cnt];
            else if (bit_cnt == 4'd8)
                sda_pull_low = 1'b0; // master ack bit
            else
            begin
                ptr          = ptr + 1'b1;
                sh           = mem[ptr];
                bit_cnt      = '0;
                sda_pull_low = !sh[7];
            end
        end
    endtask

    always @(scl or sda)
    begin
        if (scl && scl_q && sda_q && !sda)
        begin
            // start or repeated start
            active       = 1'b1;
            sending      = 1'b0;
            bit_cnt      = '0;
            byte_idx     = 0;
            sda_pull_low = 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            active       = 1'b0; // stop
            sending      = 1'b0;
            sda_pull_low = 1'b0;
        end
        else if (scl && !scl_q)
            clock_rise();
        else if (!scl && scl_q)
            clock_fall();
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== tb_eeprom_ctrl.sv ====
`include "eeprom_consts.svh"

module tb_eeprom_ctrl
    import eeprom_xfer_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BIT_CYCLES = 4 * `EE_QTR_CYCLES;
    localparam int N_XFERS    = 93; // 2 + 80 + 5 + 4 + 2
    localparam int TIMEOUT_NS = N_XFERS * 50 * BIT_CYCLES * 20 * 2;

    logic     CLK;
    logic     RESET;
    logic     req;
    logic     we;
    ee_addr_t addr;
    ee_data_t wdata;
    logic     ack;
    ee_data_t rdata;
    logic     nack;
    logic     scl;
    logic     sda_pull_low;
    logic     model_pull_low;
    logic     model_on;
    wire      sda;

    ee_data_t shadow [0:(1 << `EE_ADDR_W) - 1];
    string    test_name;
    logic     exp_nack;
    logic     exp_read;
    ee_data_t exp_data;
    logic     ack_q;
    int       errors;
    int       errors_base;
    int       checks;
    int       tests;

    assign sda = !(sda_pull_low || model_pull_low); // open-drain wired-and

    eeprom_ctrl_top UUT (
        .CLK          (CLK),
        .RESET        (RESET),
        .req          (req),
        .we           (we),
        .addr         (addr),
        .wdata        (wdata),
        .sda_in       (sda),
        .ack          (ack),
        .rdata        (rdata),
        .nack         (nack),
        .scl          (scl),
        .sda_pull_low (sda_pull_low)
    );

    tb_eeprom_model slave (
        .scl          (scl),
        .sda          (sda),
        .enable       (model_on),
        .sda_pull_low (model_pull_low)
    );

    initial
        CLK = 1'b0;

    always #10 CLK = ~CLK;

    function automatic ee_data_t fill_byte(input ee_addr_t a);
        return a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
    endfunction

    // expected read value; a silent slave gives nack and takes no write
    function automatic ee_data_t predict(input logic wr, input ee_addr_t a,
                                         input ee_data_t d, input logic slave_on,
                                         output logic nk);
        nk = !slave_on;
        if (slave_on && wr)
            shadow[a] = d;
        return shadow[a];
    endfunction

    task automatic check_bit(input string what, input logic expected, input logic actual);
        checks = checks + 1;
        if (actual !== expected)
        begin
            errors = errors + 1;
            $display("Mismatch %s %s: expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        errors_base = errors;
    endtask

    task automatic end_test;
        tests = tests + 1;
        if (errors == errors_base)
            $display("test %s: ok", test_name);
        else
            $display("test %s: FAIL with %0d errors", test_name, errors - errors_base);
    endtask

    // one four-phase request, req optionally held after ack
    task automatic transfer(input logic wr, input ee_addr_t a, input ee_data_t d,
                            input int hold);
        @(posedge CLK);
        #2;
        exp_data = predict(wr, a, d, model_on, exp_nack);
        exp_read = !wr;
        we       = wr;
        addr     = a;
        wdata    = d;
        req      = 1'b1;
        while (!ack)
            @(negedge CLK);
        repeat (hold)
        begin
            @(negedge CLK);
            check_bit("ack while req held", 1'b1, ack);
            check_bit("scl while req held", 1'b1, scl);
            check_bit("sda_pull_low while req held", 1'b0, sda_pull_low);
        end
        @(posedge CLK);
        #2;
        req = 1'b0;
        while (ack)
            @(negedge CLK);
    endtask

    // compare at each rising ack
    always @(negedge CLK)
    begin
        if (ack && !ack_q)
        begin
            check_bit("nack", exp_nack, nack);
            check_bit("scl after stop", 1'b1, scl);
            check_bit("sda after stop", 1'b1, sda);
            if (exp_read && !exp_nack)
            begin
                checks = checks + 1;
                if (rdata !== exp_data)
                begin
                    errors = errors + 1;
                    $display("Mismatch %s rdata at %h: expected %h actual %h",
                             test_name, addr, exp_data, rdata);
                end
            end
        end
        ack_q = ack;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the transfers did not finish within %0d ns", TIMEOUT_NS);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        ee_addr_t a;
        ee_data_t d;

        void'($urandom(32'h73ec));
        RESET     = 1'b1;
        req       = 1'b0;
        we        = 1'b0;
        addr      = '0;
        wdata     = '0;
        model_on  = 1'b1;
        ack_q     = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        exp_nack  = 1'b0;
        exp_read  = 1'b0;
        exp_data  = '0;
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
            shadow[i] = fill_byte(i[10:0]);

        repeat (3) @(posedge CLK);
        #2;
        RESET = 1'b0;

        begin_test("reset_idle");
        repeat (2) @(negedge CLK);
        check_bit("ack", 1'b0, ack);
        check_bit("scl", 1'b1, scl);
        check_bit("sda_pull_low", 1'b0, sda_pull_low);
        end_test();

        begin_test("write_read");
        transfer(1'b1, 11'h155, 8'ha5, 0);
        transfer(1'b0, 11'h155, 8'h00, 0);
        end_test();

        begin_test("random_blocks");
        for (int i = 0; i < 40; i++)
        begin
            a = {3'(i), 8'($urandom)}; // walks all eight blocks
            d = 8'($urandom);
            if ($urandom % 4 != 0)
                transfer(1'b1, a, d, 0);
            transfer(1'b0, a, 8'h00, 0);
        end
        end_test();

        begin_test("overwrite");
        a = 11'($urandom);
        transfer(1'b1, a, 8'h3c, 0);
        transfer(1'b1, a + 1'b1, 8'hc3, 0);
        transfer(1'b1, a, 8'h5a, 0);
        transfer(1'b0, a, 8'h00, 0);
        transfer(1'b0, a + 1'b1, 8'h00, 0);
        end_test();

        begin_test("no_slave");
        @(posedge CLK);
        #2;
        model_on = 1'b0;
        transfer(1'b1, 11'h6e1, 8'h99, 0);
        transfer(1'b0, 11'h6e1, 8'h00, 0);
        @(posedge CLK);
        #2;
        model_on = 1'b1;
        transfer(1'b1, 11'h6e1, 8'h77, 0);
        transfer(1'b0, 11'h6e1, 8'h00, 0);
        end_test();

        begin_test("req_held");
        transfer(1'b1, 11'h2f0, 8'h81, 20);
        repeat (2)
        begin
            @(negedge CLK);
            check_bit("scl after req fell", 1'b1, scl);
        end
        transfer(1'b0, 11'h2f0, 8'h00, 0);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== eeprom_ctrl_top.f ====
+incdir+.
i2c_bus_pkg.sv
eeprom_xfer_pkg.sv
i2c_bit_engine.sv
eeprom_xfer_fsm.sv
eeprom_ctrl_top.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv
